/* hw/trigPkg.sv */
`default_nettype none

package trigPkg;

   // ********************
   // sizes
   // ********************

   // trigger lanes and bits per lane
   localparam int NUM_LANES  = 4;
   localparam int LANE_WIDTH = 16;
   // multiplicity sum, wide enough for a full lane
   localparam int SUM_WIDTH  = 8;
   // host bus
   localparam int ADDR_WIDTH = 9;
   localparam int DATA_WIDTH = 32;

   // product id in upper half, variant and build in lower half
   localparam logic [DATA_WIDTH-1:0] SYS_REVISION = 32'hB100_0001;
   // returned when the output block is neither config nor results
   localparam logic [DATA_WIDTH-1:0] BLOCK_FILL   = 32'h0000_0123;

   // ********************
   // register map
   // ********************

   // word addresses
   typedef enum logic [ADDR_WIDTH-1:0] {
      REG_CSR          = 9'h000,
      REG_VERSION      = 9'h001,
      REG_OUTBLOCK     = 9'h003,
      REG_COINC_RESULT = 9'h005,
      REG_CLEAR        = 9'h009,
      REG_NUMTRIG_LO   = 9'h00A,
      REG_NUMTRIG_HI   = 9'h00B,
      REG_TICKS_LO     = 9'h00C,
      REG_TICKS_HI     = 9'h00D,
      // lane bases, lane i at base + i
      REG_COINC_MASK   = 9'h108,
      REG_MULT_MASK    = 9'h110,
      REG_PATTERN      = 9'h118,
      REG_THRESHOLD    = 9'h120
   } regAddr_e;

   // readback source
   typedef enum logic [1:0] {
      BLK_CONFIG  = 2'd0,
      BLK_RESULTS = 2'd1
   } outBlock_e;

   // ********************
   // bundles
   // ********************

   // one host request, wrEn and rdEn exclusive
   typedef struct packed {
      logic                    wrEn;
      logic                    rdEn;
      logic [DATA_WIDTH/8-1:0] wstrb;
      logic [ADDR_WIDTH-1:0]   addr;
      logic [DATA_WIDTH-1:0]   wrData;
   } busReq_t;

   // per-lane setup
   typedef struct packed {
      logic [LANE_WIDTH-1:0] coincMask;
      logic [LANE_WIDTH-1:0] multMask;
      logic [LANE_WIDTH-1:0] pattern;
      logic [SUM_WIDTH-1:0]  threshold;
   } laneCfg_t;

   // per-lane flags and multiplicity sum
   typedef struct packed {
      logic                 coincHit;
      logic                 multHit;
      logic [SUM_WIDTH-1:0] sum;
   } laneResult_t;

   // address of lane i inside a lane-indexed group
   function automatic logic [ADDR_WIDTH-1:0] laneAddr(input regAddr_e base, input int lane);
      return base + ADDR_WIDTH'(lane);
   endfunction

endpackage

`default_nettype wire

/* hw/trigLane.sv */
`timescale 1ns/1ps
`default_nettype none

module trigLane
   import trigPkg::*;
#(
   parameter int LANE_WIDTH = trigPkg::LANE_WIDTH
)
(
   input  logic                  proc_clk,
   input  logic                  rstN,
   input  logic [LANE_WIDTH-1:0] laneIn,
   input  laneCfg_t              cfg,
   output laneResult_t           result
);

   // nibble groups feeding the adder tree
   localparam int GROUPS = LANE_WIDTH / 4;

   logic [LANE_WIDTH-1:0]   multMasked;
   logic                    coincNow;
   // partial counts, 0..4 each
   logic [GROUPS-1:0][2:0]  partNext;
   logic [GROUPS-1:0][2:0]  partSum;
   logic                    coincD1;
   logic [SUM_WIDTH-1:0]    thrD1;
   logic [SUM_WIDTH-1:0]    total;

   // ********************
   // coincidence
   // ********************

   // pattern compared as stored, not masked
   assign coincNow   = (laneIn & cfg.coincMask) == cfg.pattern;
   assign multMasked = laneIn & cfg.multMask;

   // ********************
   // multiplicity
   // ********************

   // stage 1 input, ones per nibble
   always_comb
   begin
      for (int g = 0; g < GROUPS; g++)
      begin
         partNext[g] = '0;
         for (int b = 0; b < 4; b++)
         begin
            partNext[g] = partNext[g] + 3'(multMasked[4*g + b]);
         end
      end
   end

   // stage 2 input, total of the partials
   always_comb
   begin
      total = '0;
      for (int g = 0; g < GROUPS; g++)
      begin
         total = total + SUM_WIDTH'(partSum[g]);
      end
   end

   // stage 1 regs
   // coinc flag and threshold ride along so all three outputs align
   always_ff @(posedge proc_clk)
   begin
      partSum <= partNext;
      coincD1 <= coincNow;
      thrD1   <= cfg.threshold;
   end

   // stage 2, result register
   always_ff @(posedge proc_clk)
   begin
      if (!rstN)
      begin
         result <= '0;
      end
      else
      begin
         result.coincHit <= coincD1;
         result.sum      <= total;
         // at or above threshold
         result.multHit  <= total >= thrD1;
      end
   end

   // a lane can never count more bits than it has
   assert property (@(posedge proc_clk) disable iff (!rstN)
      result.sum <= SUM_WIDTH'(LANE_WIDTH));

endmodule

`default_nettype wire

/* hw/trigResults.sv */
`timescale 1ns/1ps
`default_nettype none

module trigResults
   import trigPkg::*;
#(
   parameter int NUM_LANES = trigPkg::NUM_LANES
)
(
   input  logic                        proc_clk,
   input  logic                        rstN,
   input  laneResult_t [NUM_LANES-1:0] laneResults,
   input  logic                        fastTrig,
   input  logic                        counterClr,
   input  logic                        runEnable,
   input  logic [ADDR_WIDTH-1:0]       rdAddr,
   output logic [DATA_WIDTH-1:0]       resultWord
);

   // fastTrig sync and edge
   logic        ftA;
   logic        ftB;
   logic        ftRise;
   logic [63:0] numTrig;
   logic [63:0] runTicks;
   // coinc flags low byte, mult flags high byte
   logic [15:0] coincWord;

   // ********************
   // counters
   // ********************
   always_ff @(posedge proc_clk)
   begin
      if (!rstN)
      begin
         ftA <= 1'b0;
         ftB <= 1'b0;
      end
      else
      begin
         ftA <= fastTrig;
         ftB <= ftA;
      end
   end

   assign ftRise = ftA & ~ftB;

   // free-running tick count and rising-edge count, shared clear
   always_ff @(posedge proc_clk)
   begin
      if (!rstN || counterClr)
      begin
         runTicks <= '0;
         numTrig  <= '0;
      end
      else
      begin
         runTicks <= runTicks + 64'd1;
         if (ftRise)
            numTrig <= numTrig + 64'd1;
      end
   end

   // ********************
   // results block
   // ********************
   always_comb
   begin
      coincWord = '0;
      for (int i = 0; i < NUM_LANES; i++)
      begin
         coincWord[i]     = laneResults[i].coincHit;
         coincWord[8 + i] = laneResults[i].multHit;
      end
   end

   // address to word, anything unmapped is zero
   always_comb
   begin
      case (rdAddr)
         REG_CSR:          resultWord = DATA_WIDTH'(runEnable);
         REG_VERSION:      resultWord = SYS_REVISION;
         REG_COINC_RESULT: resultWord = DATA_WIDTH'(coincWord);
         REG_NUMTRIG_LO:   resultWord = numTrig[31:0];
         REG_NUMTRIG_HI:   resultWord = numTrig[63:32];
         REG_TICKS_LO:     resultWord = runTicks[31:0];
         REG_TICKS_HI:     resultWord = runTicks[63:32];
         default:          resultWord = '0;
      endcase
      // sums share the mult-mask addresses
      for (int i = 0; i < NUM_LANES; i++)
      begin
         if (rdAddr == laneAddr(REG_MULT_MASK, i))
            resultWord = DATA_WIDTH'(laneResults[i].sum);
      end
   end

   // clear strobe from the bank restarts both counters
   assert property (@(posedge proc_clk) disable iff (!rstN)
      counterClr |=> (runTicks == '0) && (numTrig == '0));

endmodule

`default_nettype wire

/* hw/trigRegBank.sv */
`timescale 1ns/1ps
`default_nettype none

module trigRegBank
   import trigPkg::*;
#(
   parameter int NUM_LANES  = trigPkg::NUM_LANES,
   parameter int LANE_WIDTH = trigPkg::LANE_WIDTH
)
(
   input  logic                           proc_clk,
   input  logic                           rstN,
   input  busReq_t                        busReq,
   input  logic [DATA_WIDTH-1:0]          resultWord,
   output laneCfg_t [NUM_LANES-1:0]       laneCfg,
   output logic                           counterClr,
   output logic [ADDR_WIDTH-1:0]          rdAddr,
   output logic [DATA_WIDTH-1:0]          rdData,
   output logic                           rdValid,
   output logic                           runEnable
);

   // csr keeps its low half only
   logic [15:0]           csrReg;
   outBlock_e             outBlock;
   // block 0 word for the current address
   logic [DATA_WIDTH-1:0] cfgWord;

   // byte-strobe merge of a write into a stored word
   function automatic logic [DATA_WIDTH-1:0] mergeBytes(
      input logic [DATA_WIDTH-1:0]   oldWord,
      input logic [DATA_WIDTH-1:0]   newWord,
      input logic [DATA_WIDTH/8-1:0] strb
   );
      logic [DATA_WIDTH-1:0] merged;
      merged = oldWord;
      for (int b = 0; b < DATA_WIDTH/8; b++)
      begin
         if (strb[b])
         begin
            merged[8*b +: 8] = newWord[8*b +: 8];
         end
      end
      return merged;
   endfunction

   // results side decodes the same address
   assign rdAddr    = busReq.addr;
   assign runEnable = csrReg[0];

   // ********************
   // write decode
   // ********************
   always_ff @(posedge proc_clk)
   begin
      if (!rstN)
      begin
         csrReg     <= '0;
         outBlock   <= BLK_CONFIG;
         laneCfg    <= '0;
         counterClr <= 1'b0;
         rdValid    <= 1'b0;
      end
      else
      begin
         // one-cycle clear strobe per write
         counterClr <= busReq.wrEn && (busReq.addr == REG_CLEAR);
         rdValid    <= busReq.rdEn;
         if (busReq.wrEn)
         begin
            case (busReq.addr)
               REG_CSR:
                  csrReg <= 16'(mergeBytes(DATA_WIDTH'(csrReg), busReq.wrData, busReq.wstrb));
               REG_OUTBLOCK:
                  outBlock <= outBlock_e'(2'(mergeBytes(DATA_WIDTH'(outBlock), busReq.wrData,
                                                        busReq.wstrb)));
               default:
                  ;
            endcase
            // lane groups, one word per lane
            for (int i = 0; i < NUM_LANES; i++)
            begin
               if (busReq.addr == laneAddr(REG_COINC_MASK, i))
               begin
                  laneCfg[i].coincMask <= LANE_WIDTH'(mergeBytes(
                     DATA_WIDTH'(laneCfg[i].coincMask), busReq.wrData, busReq.wstrb));
               end
               if (busReq.addr == laneAddr(REG_MULT_MASK, i))
               begin
                  laneCfg[i].multMask <= LANE_WIDTH'(mergeBytes(
                     DATA_WIDTH'(laneCfg[i].multMask), busReq.wrData, busReq.wstrb));
               end
               if (busReq.addr == laneAddr(REG_PATTERN, i))
               begin
                  laneCfg[i].pattern <= LANE_WIDTH'(mergeBytes(
                     DATA_WIDTH'(laneCfg[i].pattern), busReq.wrData, busReq.wstrb));
               end
               if (busReq.addr == laneAddr(REG_THRESHOLD, i))
               begin
                  laneCfg[i].threshold <= SUM_WIDTH'(mergeBytes(
                     DATA_WIDTH'(laneCfg[i].threshold), busReq.wrData, busReq.wstrb));
               end
            end
         end
      end
   end

   // ********************
   // readback
   // ********************

   // block 0 view, unmapped words stay zero
   always_comb
   begin
      case (busReq.addr)
         REG_CSR:      cfgWord = DATA_WIDTH'(csrReg);
         REG_OUTBLOCK: cfgWord = DATA_WIDTH'(outBlock);
         default:      cfgWord = '0;
      endcase
      for (int i = 0; i < NUM_LANES; i++)
      begin
         if (busReq.addr == laneAddr(REG_COINC_MASK, i))
            cfgWord = DATA_WIDTH'(laneCfg[i].coincMask);
         if (busReq.addr == laneAddr(REG_MULT_MASK, i))
            cfgWord = DATA_WIDTH'(laneCfg[i].multMask);
         if (busReq.addr == laneAddr(REG_PATTERN, i))
            cfgWord = DATA_WIDTH'(laneCfg[i].pattern);
         if (busReq.addr == laneAddr(REG_THRESHOLD, i))
            cfgWord = DATA_WIDTH'(laneCfg[i].threshold);
      end
   end

   // read data lands one cycle after rdEn
   always_ff @(posedge proc_clk)
   begin
      if (busReq.rdEn)
      begin
         case (outBlock)
            BLK_CONFIG:  rdData <= cfgWord;
            BLK_RESULTS: rdData <= resultWord;
            default:     rdData <= BLOCK_FILL;
         endcase
      end
   end

   // host never issues read and write together
   assert property (@(posedge proc_clk) disable iff (!rstN)
      !(busReq.wrEn && busReq.rdEn));

   // fixed single-cycle read latency
   assert property (@(posedge proc_clk) disable iff (!rstN)
      busReq.rdEn |=> rdValid);

endmodule

`default_nettype wire

/* hw/trigCoincTop.sv */
`timescale 1ns/1ps
`default_nettype none

module trigCoincTop
   import trigPkg::*;
#(
   parameter int NUM_LANES  = trigPkg::NUM_LANES,
   parameter int LANE_WIDTH = trigPkg::LANE_WIDTH
)
(
   input  logic                            proc_clk,
   input  logic                            rstN,
   input  busReq_t                         busReq,
   input  logic [NUM_LANES*LANE_WIDTH-1:0] trigIn,
   input  logic                            fastTrig,
   output logic [DATA_WIDTH-1:0]           rdData,
   output logic                            rdValid
);

   // bank to lanes
   laneCfg_t [NUM_LANES-1:0]    laneCfg;
   // lanes to result stage
   laneResult_t [NUM_LANES-1:0] laneResults;
   logic                        counterClr;
   logic                        runEnable;
   logic [ADDR_WIDTH-1:0]       rdAddr;
   logic [DATA_WIDTH-1:0]       resultWord;

   // ********************
   // host registers
   // ********************
   trigRegBank #(
      .NUM_LANES  (NUM_LANES),
      .LANE_WIDTH (LANE_WIDTH)
   ) uRegBank (
      .proc_clk   (proc_clk),
      .rstN       (rstN),
      .busReq     (busReq),
      .resultWord (resultWord),
      .laneCfg    (laneCfg),
      .counterClr (counterClr),
      .rdAddr     (rdAddr),
      .rdData     (rdData),
      .rdValid    (rdValid),
      .runEnable  (runEnable)
   );

   // ********************
   // lanes
   // ********************
   // lane i takes slice i of trigIn
   for (genvar i = 0; i < NUM_LANES; i++)
   begin : genLane
      trigLane #(
         .LANE_WIDTH (LANE_WIDTH)
      ) uLane (
         .proc_clk (proc_clk),
         .rstN     (rstN),
         .laneIn   (trigIn[i*LANE_WIDTH +: LANE_WIDTH]),
         .cfg      (laneCfg[i]),
         .result   (laneResults[i])
      );
   end

   // counters and results block
   trigResults #(
      .NUM_LANES (NUM_LANES)
   ) uResults (
      .proc_clk    (proc_clk),
      .rstN        (rstN),
      .laneResults (laneResults),
      .fastTrig    (fastTrig),
      .counterClr  (counterClr),
      .runEnable   (runEnable),
      .rdAddr      (rdAddr),
      .resultWord  (resultWord)
   );

endmodule

`default_nettype wire

/* verif/trigChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module trigChecker
   import trigPkg::*;
#(
   parameter int NUM_LANES  = trigPkg::NUM_LANES,
   parameter int LANE_WIDTH = trigPkg::LANE_WIDTH
)
(
   input  logic                            proc_clk,
   input  logic                            rstN,
   input  busReq_t                         busReq,
   input  logic [NUM_LANES*LANE_WIDTH-1:0] trigIn,
   input  logic                            fastTrig,
   input  logic                            rdValid,
   input  logic [DATA_WIDTH-1:0]           rdData,
   output int                              errCount,
   output int                              readCount
);

   // shadow of host-visible config, kept as full merged words
   logic [DATA_WIDTH-1:0] csrSh;
   logic [DATA_WIDTH-1:0] blkSh;
   logic [DATA_WIDTH-1:0] coincMaskSh [NUM_LANES];
   logic [DATA_WIDTH-1:0] multMaskSh  [NUM_LANES];
   logic [DATA_WIDTH-1:0] patternSh   [NUM_LANES];
   logic [DATA_WIDTH-1:0] thrSh       [NUM_LANES];
   // counter models
   logic [63:0]           ticksModel;
   logic [63:0]           trigModel;
   logic                  clrPend;
   logic                  ftPrev;
   // read waiting for its response
   logic                  expPend;
   logic [ADDR_WIDTH-1:0] expAddr;
   logic [DATA_WIDTH-1:0] expWord;
   int                    errs = 0;
   int                    reads = 0;

   assign errCount  = errs;
   assign readCount = reads;

   // ********************
   // reference model
   // ********************

   // bytes with strobe set come from the new word
   function automatic logic [DATA_WIDTH-1:0] withStrobe(
      input logic [DATA_WIDTH-1:0] oldW,
      input logic [DATA_WIDTH-1:0] newW,
      input logic [3:0]            strb
   );
      logic [DATA_WIDTH-1:0] w;
      w = oldW;
      for (int b = 0; b < 4; b++)
      begin
         if (strb[b])
            w[8*b +: 8] = newW[8*b +: 8];
      end
      return w;
   endfunction

   function automatic int countOnes(input logic [LANE_WIDTH-1:0] v);
      int n;
      n = 0;
      for (int b = 0; b < LANE_WIDTH; b++)
      begin
         if (v[b])
            n++;
      end
      return n;
   endfunction

   // expected read word from shadow, inputs and counter models
   function automatic logic [DATA_WIDTH-1:0] expectWord(input logic [ADDR_WIDTH-1:0] addr);
      logic [DATA_WIDTH-1:0] w;
      logic [LANE_WIDTH-1:0] laneBits;
      int a;
      int ones;
      a = int'(addr);
      w = '0;
      if (blkSh[1:0] == 2'd0)
      begin
         // config block, only mapped words are nonzero
         if (a == int'(REG_CSR))
            w = csrSh & 32'h0000_FFFF;
         if (a == int'(REG_OUTBLOCK))
            w = blkSh & 32'h0000_0003;
         for (int i = 0; i < NUM_LANES; i++)
         begin
            if (a == int'(REG_COINC_MASK) + i)
               w = 32'(coincMaskSh[i][LANE_WIDTH-1:0]);
            if (a == int'(REG_MULT_MASK) + i)
               w = 32'(multMaskSh[i][LANE_WIDTH-1:0]);
            if (a == int'(REG_PATTERN) + i)
               w = 32'(patternSh[i][LANE_WIDTH-1:0]);
            if (a == int'(REG_THRESHOLD) + i)
               w = 32'(thrSh[i][SUM_WIDTH-1:0]);
         end
      end
      else if (blkSh[1:0] == 2'd1)
      begin
         case (a)
            int'(REG_CSR):        w = {31'd0, csrSh[0]};
            int'(REG_VERSION):    w = SYS_REVISION;
            int'(REG_NUMTRIG_LO): w = trigModel[31:0];
            int'(REG_NUMTRIG_HI): w = trigModel[63:32];
            int'(REG_TICKS_LO):   w = ticksModel[31:0];
            int'(REG_TICKS_HI):   w = ticksModel[63:32];
            default:              w = '0;
         endcase
         for (int i = 0; i < NUM_LANES; i++)
         begin
            laneBits = trigIn[i*LANE_WIDTH +: LANE_WIDTH];
            ones     = countOnes(laneBits & multMaskSh[i][LANE_WIDTH-1:0]);
            if (a == int'(REG_COINC_RESULT))
            begin
               // coinc flags low byte, threshold flags from bit 8
               w[i]     = (laneBits & coincMaskSh[i][LANE_WIDTH-1:0])
                          == patternSh[i][LANE_WIDTH-1:0];
               w[8 + i] = ones >= int'(thrSh[i][SUM_WIDTH-1:0]);
            end
            if (a == int'(REG_MULT_MASK) + i)
               w = 32'(ones);
         end
      end
      else
      begin
         w = BLOCK_FILL;
      end
      return w;
   endfunction

   task automatic applyWrite(
      input logic [ADDR_WIDTH-1:0] addr,
      input logic [DATA_WIDTH-1:0] data,
      input logic [3:0]            strb
   );
      int a;
      a = int'(addr);
      if (a == int'(REG_CSR))
         csrSh = withStrobe(csrSh, data, strb);
      if (a == int'(REG_OUTBLOCK))
         blkSh = withStrobe(blkSh, data, strb);
      for (int i = 0; i < NUM_LANES; i++)
      begin
         if (a == int'(REG_COINC_MASK) + i)
            coincMaskSh[i] = withStrobe(coincMaskSh[i], data, strb);
         if (a == int'(REG_MULT_MASK) + i)
            multMaskSh[i] = withStrobe(multMaskSh[i], data, strb);
         if (a == int'(REG_PATTERN) + i)
            patternSh[i] = withStrobe(patternSh[i], data, strb);
         if (a == int'(REG_THRESHOLD) + i)
            thrSh[i] = withStrobe(thrSh[i], data, strb);
      end
   endtask

   // ********************
   // compare
   // ********************
   always @(posedge proc_clk)
   begin
      if (!rstN)
      begin
         csrSh      = '0;
         blkSh      = '0;
         ticksModel = '0;
         trigModel  = '0;
         clrPend    = 1'b0;
         ftPrev     = 1'b0;
         expPend    = 1'b0;
         for (int i = 0; i < NUM_LANES; i++)
         begin
            coincMaskSh[i] = '0;
            multMaskSh[i]  = '0;
            patternSh[i]   = '0;
            thrSh[i]       = '0;
         end
      end
      else
      begin
         // response to the request seen one edge ago
         if (expPend)
         begin
            reads++;
            if (!rdValid)
            begin
               errs++;
               $display("no rdValid one cycle after the read of address %h", expAddr);
            end
            else if (rdData !== expWord)
            begin
               errs++;
               $display("Error at %0t ns: read of %h expected %h got %h",
                        $time, expAddr, expWord, rdData);
            end
         end
         else if (rdValid)
         begin
            errs++;
            $display("rdValid high at %0t ns with no read request", $time);
         end
         // expected value uses state before this edge
         expPend = busReq.rdEn;
         if (busReq.rdEn)
         begin
            expAddr = busReq.addr;
            expWord = expectWord(busReq.addr);
         end
         if (busReq.wrEn)
            applyWrite(busReq.addr, busReq.wrData, busReq.wstrb);
         // clear lands one edge after the clear write
         if (clrPend)
         begin
            ticksModel = '0;
            trigModel  = '0;
         end
         else
         begin
            ticksModel = ticksModel + 64'd1;
            if (fastTrig && !ftPrev)
               trigModel = trigModel + 64'd1;
         end
         ftPrev  = fastTrig;
         clrPend = busReq.wrEn && (busReq.addr == REG_CLEAR);
      end
   end

endmodule

`default_nettype wire

/* verif/tbTrigTop.sv */
`timescale 1ns/1ps
`default_nettype none

module tbTrigTop
   import trigPkg::*;
();

   localparam int RD_TIMEOUT  = 16;
   localparam int HOLD_CYCLES = 4;

   logic                            proc_clk;
   logic                            rstN;
   busReq_t                         busReq;
   logic [NUM_LANES*LANE_WIDTH-1:0] trigIn;
   logic                            fastTrig;
   logic [DATA_WIDTH-1:0]           rdData;
   logic                            rdValid;
   int                              chkErrors;
   int                              chkReads;
   int                              tbErrors;
   int                              testsRun;
   int                              testsBad;
   int                              errMark;
   int                              reqCycle;
   int                              cycleCount = 0;
   // holes in the map, plus words only the results block serves
   logic [ADDR_WIDTH-1:0] unmappedAddrs [8] = '{9'h001, 9'h002, 9'h004, 9'h009,
                                                9'h00C, 9'h10C, 9'h124, 9'h1FF};

   trigCoincTop #(
      .NUM_LANES  (NUM_LANES),
      .LANE_WIDTH (LANE_WIDTH)
   ) dut0 (
      .proc_clk (proc_clk),
      .rstN     (rstN),
      .busReq   (busReq),
      .trigIn   (trigIn),
      .fastTrig (fastTrig),
      .rdData   (rdData),
      .rdValid  (rdValid)
   );

   trigChecker #(
      .NUM_LANES  (NUM_LANES),
      .LANE_WIDTH (LANE_WIDTH)
   ) uChecker (
      .proc_clk  (proc_clk),
      .rstN      (rstN),
      .busReq    (busReq),
      .trigIn    (trigIn),
      .fastTrig  (fastTrig),
      .rdValid   (rdValid),
      .rdData    (rdData),
      .errCount  (chkErrors),
      .readCount (chkReads)
   );

   // 8 ns period
   initial
   begin
      proc_clk = 1'b0;
      forever #4 proc_clk = ~proc_clk;
   end

   always @(posedge proc_clk)
      cycleCount <= cycleCount + 1;

   // ********************
   // bus tasks
   // ********************

   // inputs change 1 ns after the edge
   task automatic nextCycle();
      @(posedge proc_clk);
      #1;
   endtask

   task automatic holdCycles(input int n);
      busReq = '0;
      repeat (n) nextCycle();
   endtask

   task automatic writeReg(
      input logic [ADDR_WIDTH-1:0] addr,
      input logic [DATA_WIDTH-1:0] data,
      input logic [3:0]            strb
   );
      busReq        = '0;
      busReq.wrEn   = 1'b1;
      busReq.wstrb  = strb;
      busReq.addr   = addr;
      busReq.wrData = data;
      nextCycle();
      busReq = '0;
   endtask

   task automatic readReg(input logic [ADDR_WIDTH-1:0] addr, output logic [DATA_WIDTH-1:0] data);
      int waitCount;
      busReq      = '0;
      busReq.rdEn = 1'b1;
      busReq.addr = addr;
      reqCycle    = cycleCount;
      nextCycle();
      busReq    = '0;
      waitCount = 0;
      while (!rdValid && waitCount < RD_TIMEOUT)
      begin
         nextCycle();
         waitCount++;
      end
      if (!rdValid)
      begin
         $display("timeout: no read response for address %h", addr);
         $display("=== FAIL ===");
         $finish;
      end
      else
      begin
         data = rdData;
      end
   endtask

   task automatic expectValue(input string what, input logic [31:0] got, input logic [31:0] want);
      if (got !== want)
      begin
         tbErrors++;
         $display("Error at %0t ns: %s read %h, expected %h", $time, what, got, want);
      end
   endtask

   task automatic beginTest();
      errMark = chkErrors + tbErrors;
   endtask

   // two idle edges let the checker see the last response
   task automatic endTest(input string name);
      holdCycles(2);
      testsRun++;
      if (chkErrors + tbErrors != errMark)
      begin
         testsBad++;
         $display("test %0d %s: errors", testsRun, name);
      end
      else
      begin
         $display("test %0d %s: ok", testsRun, name);
      end
   endtask

   // csr or a lane word, lane groups 8 words apart
   function automatic logic [ADDR_WIDTH-1:0] pickConfigAddr();
      int sel;
      sel = int'($urandom_range(16, 0));
      if (sel == 16)
         return REG_CSR;
      return 9'(int'(REG_COINC_MASK) + 8 * (sel / 4) + sel % 4);
   endfunction

   // random lane setup, about half the patterns built to hit
   task automatic setupLanes(input bit allOnes);
      logic [LANE_WIDTH-1:0] inBits;
      logic [LANE_WIDTH-1:0] cMask;
      logic [LANE_WIDTH-1:0] mMask;
      logic [LANE_WIDTH-1:0] pat;
      for (int i = 0; i < NUM_LANES; i++)
      begin
         inBits = allOnes ? '1 : LANE_WIDTH'($urandom);
         cMask  = LANE_WIDTH'($urandom);
         mMask  = allOnes ? '1 : LANE_WIDTH'($urandom);
         pat    = ($urandom_range(1, 0) == 0) ? (inBits & cMask) : LANE_WIDTH'($urandom);
         trigIn[i*LANE_WIDTH +: LANE_WIDTH] = inBits;
         writeReg(9'(int'(REG_COINC_MASK) + i), 32'(cMask), 4'hF);
         writeReg(9'(int'(REG_MULT_MASK) + i), 32'(mMask), 4'hF);
         writeReg(9'(int'(REG_PATTERN) + i), 32'(pat), 4'hF);
         writeReg(9'(int'(REG_THRESHOLD) + i), 32'($urandom_range(17, 0)), 4'hF);
      end
      // lanes settle in 2 cycles
      holdCycles(HOLD_CYCLES);
   endtask

   // ********************
   // test sequence
   // ********************
   initial
   begin
      logic [DATA_WIDTH-1:0] word;
      logic [DATA_WIDTH-1:0] ticksA;
      logic [DATA_WIDTH-1:0] ticksB;
      logic [ADDR_WIDTH-1:0] addr;
      int                    cycA;
      int                    pulses;
      void'($urandom(32'hc2fdd7e4));
      rstN     = 1'b0;
      busReq   = '0;
      trigIn   = '0;
      fastTrig = 1'b0;
      tbErrors = 0;
      testsRun = 0;
      testsBad = 0;
      repeat (3) @(posedge proc_clk);
      #1;
      rstN = 1'b1;
      nextCycle();

      // byte-strobed writes read back merged
      beginTest();
      writeReg(REG_OUTBLOCK, $urandom & 32'hFFFF_FFFC, 4'hF);
      readReg(REG_OUTBLOCK, word);
      for (int k = 0; k < 24; k++)
      begin
         addr = pickConfigAddr();
         writeReg(addr, $urandom, 4'($urandom));
         readReg(addr, word);
      end
      writeReg(9'h002, $urandom, 4'hF);
      foreach (unmappedAddrs[j])
         readReg(unmappedAddrs[j], word);
      endTest("config readback");

      beginTest();
      writeReg(REG_OUTBLOCK, 32'h1, 4'h1);
      // run enable as seen through the results block
      readReg(REG_CSR, word);
      for (int r = 0; r < 12; r++)
      begin
         setupLanes(1'b0);
         readReg(REG_COINC_RESULT, word);
      end
      endTest("coincidence");

      // first round saturates every lane
      beginTest();
      for (int r = 0; r < 8; r++)
      begin
         setupLanes(r == 0);
         for (int i = 0; i < NUM_LANES; i++)
            readReg(9'(int'(REG_MULT_MASK) + i), word);
         readReg(REG_COINC_RESULT, word);
      end
      endTest("multiplicity");

      beginTest();
      writeReg(REG_CLEAR, '0, 4'hF);
      holdCycles(HOLD_CYCLES);
      pulses = int'($urandom_range(12, 3));
      for (int p = 0; p < pulses; p++)
      begin
         fastTrig = 1'b1;
         repeat ($urandom_range(3, 1)) nextCycle();
         fastTrig = 1'b0;
         repeat ($urandom_range(4, 2)) nextCycle();
      end
      holdCycles(HOLD_CYCLES);
      readReg(REG_NUMTRIG_LO, word);
      expectValue("numTrig low", word, 32'(pulses));
      readReg(REG_NUMTRIG_HI, word);
      expectValue("numTrig high", word, '0);
      endTest("trigger count");

      beginTest();
      writeReg(REG_CLEAR, '0, 4'hF);
      holdCycles(2);
      readReg(REG_TICKS_LO, ticksA);
      cycA = reqCycle;
      holdCycles(int'($urandom_range(10, 3)));
      readReg(REG_TICKS_LO, ticksB);
      if (ticksB - ticksA < 32'(reqCycle - cycA))
      begin
         tbErrors++;
         $display("Error at %0t ns: runTicks advanced by %0d over %0d cycles",
                  $time, ticksB - ticksA, reqCycle - cycA);
      end
      readReg(REG_TICKS_HI, word);
      expectValue("runTicks high", word, '0);
      readReg(REG_VERSION, word);
      expectValue("version", word, SYS_REVISION);
      // blocks 2 and 3 are unknown
      writeReg(REG_OUTBLOCK, 32'h2, 4'h1);
      readReg(REG_VERSION, word);
      expectValue("block 2", word, BLOCK_FILL);
      writeReg(REG_OUTBLOCK, 32'h3, 4'h1);
      readReg(REG_COINC_RESULT, word);
      expectValue("block 3", word, BLOCK_FILL);
      writeReg(REG_OUTBLOCK, 32'h0, 4'hF);
      readReg(REG_OUTBLOCK, word);
      expectValue("block select", word, '0);
      endTest("ticks and blocks");

      $display("tests run %0d, tests with errors %0d, reads checked %0d, check errors %0d",
               testsRun, testsBad, chkReads, chkErrors + tbErrors);
      if (testsBad == 0 && chkErrors + tbErrors == 0)
      begin
         $display("=== PASS ===");
      end
      else
      begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
hw/trigPkg.sv
hw/trigLane.sv
hw/trigResults.sv
hw/trigRegBank.sv
hw/trigCoincTop.sv
verif/trigChecker.sv
verif/tbTrigTop.sv

/* run.sh */
#!/bin/sh
# build and run the trigger-logic testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD=build
LOG="$BUILD/sim.log"

mkdir -p "$BUILD"

verilator --binary --timing --assert -j 0 \
   --top-module tbTrigTop -Mdir "$BUILD/obj" -f flist.f

"$BUILD/obj/VtbTrigTop" > "$LOG" 2>&1
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
   echo "simulation failed, see $LOG"
   exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
   echo "no result line in $LOG"
   exit 1
fi
echo "simulation passed"
